//--- src/rx_decim_pkg.sv
// rates, widths, FIR taps and sample types shared by the RX decimation chain
// modules import it inside the body, port types use scoped names
package rx_decim_pkg;

  localparam int in_width = 18; // mixer sample width

  // first CIC, decimate by 48
  localparam int s1_rate      = 48;
  localparam int s1_stages    = 4;
  localparam int s1_out_width = 16;

  // second CIC, decimate by 50
  localparam int s2_rate      = 50;
  localparam int s2_stages    = 5;
  localparam int s2_out_width = 17;

  // final FIR, decimate by 2
  localparam int fir_taps      = 8;
  localparam int coef_width    = 9;
  localparam int fir_shift     = 1; // 256 tap sum, halved -> DC gain 128
  localparam int fir_acc_width = s2_out_width + coef_width + 3; // headroom for step overshoot

  // symmetric lowpass, sums to 256
  localparam logic signed [coef_width-1:0] fir_coefs [0:fir_taps-1] = '{
    -9'sd4, 9'sd8, 9'sd36, 9'sd88, 9'sd88, 9'sd36, 9'sd8, -9'sd4
  };

  localparam int out_width = 24; // output sample width

  typedef logic signed [in_width-1:0]     mix_t;
  typedef logic signed [s1_out_width-1:0] s1_out_t;
  typedef logic signed [s2_out_width-1:0] s2_out_t;
  typedef logic signed [out_width-1:0]    out_t;

  // register growth of an N-stage CIC with differential delay 1
  function automatic int cic_growth(input int stages, input int rate);
    return stages * $clog2(rate); // 24 for stage 1, 30 for stage 2
  endfunction

endpackage

//--- src/cic_integrator.sv
// one CIC integrator stage, accumulates on strobe
// data type set per instance so one module serves both accumulator widths
`timescale 1ns/1ps

module cic_integrator #(
  parameter type data_t = logic signed [31:0]
) (
  input  logic  clock,
  input  logic  rst_all,
  input  logic  strobe,   // input sample valid
  input  data_t in_data,
  output data_t out_data  // running sum
);

  always_ff @(posedge clock) begin
    if (rst_all) begin
      out_data <= '0;
    end else if (strobe) begin
      out_data <= out_data + in_data; // wraps mod 2^width, fine for CIC
    end
  end

endmodule

//--- src/cic_comb.sv
// one CIC comb stage, differentiates at the decimated rate
// delay of one output sample, updates only on the output strobe
`timescale 1ns/1ps

module cic_comb #(
  parameter type data_t = logic signed [31:0]
) (
  input  logic  clock,
  input  logic  rst_all,
  input  logic  strobe,   // decimated sample valid
  input  data_t in_data,
  output data_t out_data  // x[n] - x[n-1]
);

  data_t prev_data; // x[n-1]

  always_ff @(posedge clock) begin
    if (rst_all) begin
      prev_data <= '0;
      out_data  <= '0;
    end else if (strobe) begin
      prev_data <= in_data;
      out_data  <= in_data - prev_data; // modular difference undoes integrator wrap
    end
  end

endmodule

//--- src/cic_decimator.sv
// generic CIC decimator, integrators at input rate and combs at output rate
// full precision inside, output is the top out_bits of the last comb
`timescale 1ns/1ps

module cic_decimator #(
  parameter int stages   = rx_decim_pkg::s1_stages,
  parameter int rate     = rx_decim_pkg::s1_rate,
  parameter int in_bits  = rx_decim_pkg::in_width,
  parameter int out_bits = rx_decim_pkg::s1_out_width
) (
  input  logic                       clock,
  input  logic                       rst_all,
  input  logic                       in_strobe,  // input sample valid
  input  logic                       out_strobe, // decimated sample tick
  input  logic signed [in_bits-1:0]  in_data,
  output logic signed [out_bits-1:0] out_data
);

  import rx_decim_pkg::*;

  // 42 bits for stage 1, 46 for stage 2
  localparam int acc_bits = in_bits + cic_growth(stages, rate);

  typedef logic signed [acc_bits-1:0] acc_t;

  acc_t integ_data [0:stages]; // [0] is the extended input
  acc_t comb_data  [0:stages]; // [0] is the last integrator

  assign integ_data[0] = acc_t'(in_data); // sign extend

  for (genvar k = 0; k < stages; k++) begin : g_integ
    cic_integrator #(
      .data_t(acc_t)
    ) integ_i (
      .clock   (clock),
      .rst_all (rst_all),
      .strobe  (in_strobe),
      .in_data (integ_data[k]),
      .out_data(integ_data[k+1])
    );
  end

  assign comb_data[0] = integ_data[stages]; // sampled only on out_strobe

  for (genvar k = 0; k < stages; k++) begin : g_comb
    cic_comb #(
      .data_t(acc_t)
    ) comb_i (
      .clock   (clock),
      .rst_all (rst_all),
      .strobe  (out_strobe),
      .in_data (comb_data[k]),
      .out_data(comb_data[k+1])
    );
  end

  // drop low bits, floor rounding
  assign out_data = comb_data[stages][acc_bits-1 -: out_bits];

endmodule

//--- src/decim_strobe_gen.sv
// single-cycle rate strobes for the two CIC stages
// strobe_s1 every 48 clocks, strobe_s2 every 50th strobe_s1
`timescale 1ns/1ps

module decim_strobe_gen (
  input  logic clock,
  input  logic rst_all,
  output logic strobe_s1, // 1 in 48
  output logic strobe_s2  // 1 in 2400, one clock after strobe_s1
);

  import rx_decim_pkg::*;

  localparam int cnt1_bits = $clog2(s1_rate);
  localparam int cnt2_bits = $clog2(s2_rate);

  logic [cnt1_bits-1:0] cnt1; // clock count within one s1 period
  logic [cnt2_bits-1:0] cnt2; // s1 count within one s2 period

  always_ff @(posedge clock) begin
    if (rst_all) begin
      cnt1      <= '0;
      strobe_s1 <= 1'b0;
    end else if (cnt1 == cnt1_bits'(s1_rate - 1)) begin
      cnt1      <= '0;
      strobe_s1 <= 1'b1;
    end else begin
      cnt1      <= cnt1 + 1'b1;
      strobe_s1 <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_all) begin
      cnt2      <= '0;
      strobe_s2 <= 1'b0;
    end else begin
      strobe_s2 <= 1'b0; // default, pulse only
      if (strobe_s1) begin
        if (cnt2 == cnt2_bits'(s2_rate - 1)) begin
          cnt2      <= '0;
          strobe_s2 <= 1'b1;
        end else begin
          cnt2 <= cnt2 + 1'b1;
        end
      end
    end
  end

endmodule

//--- src/fir_decim2.sv
// 8-tap halfband-style FIR, decimate by 2, I and Q share one tap sequencer
// serial MAC over 8 clocks, out_strobe 10 clocks after the starting in_strobe
`timescale 1ns/1ps

module fir_decim2 (
  input  logic                  clock,
  input  logic                  rst_all,
  input  logic                  in_strobe, // new sample from stage 2
  input  rx_decim_pkg::s2_out_t in_i,
  input  rx_decim_pkg::s2_out_t in_q,
  output logic                  out_strobe,
  output rx_decim_pkg::out_t    out_i,
  output rx_decim_pkg::out_t    out_q
);

  import rx_decim_pkg::*;

  localparam int tap_bits  = $clog2(fir_taps);
  localparam int prod_bits = s2_out_width + coef_width;

  typedef logic signed [fir_acc_width-1:0] acc_t;
  typedef logic signed [prod_bits-1:0]     prod_t;

  s2_out_t             dly_i [0:fir_taps-1]; // [0] newest
  s2_out_t             dly_q [0:fir_taps-1];
  logic                phase;   // set after an odd input, compute on the next one
  logic                busy;    // MAC running
  logic                last;    // final tap accumulated, acc is complete
  logic [tap_bits-1:0] tap;
  acc_t                acc_i;
  acc_t                acc_q;
  prod_t               prod_i;
  prod_t               prod_q;

  // both channels use the same coefficient each cycle
  assign prod_i = dly_i[tap] * fir_coefs[tap];
  assign prod_q = dly_q[tap] * fir_coefs[tap];

  always_ff @(posedge clock) begin
    if (rst_all) begin
      phase      <= 1'b0;
      busy       <= 1'b0;
      last       <= 1'b0;
      tap        <= '0;
      out_strobe <= 1'b0;
      out_i      <= '0;
      out_q      <= '0;
      for (int k = 0; k < fir_taps; k++) begin
        dly_i[k] <= '0; // stale history would leak into the first outputs
        dly_q[k] <= '0;
      end
    end else begin
      out_strobe <= 1'b0;
      last       <= 1'b0;

      if (in_strobe) begin
        dly_i[0] <= in_i;
        dly_q[0] <= in_q;
        for (int k = 1; k < fir_taps; k++) begin
          dly_i[k] <= dly_i[k-1];
          dly_q[k] <= dly_q[k-1];
        end
        phase <= ~phase;
        if (phase) begin
          busy <= 1'b1; // every second sample
          tap  <= '0;
        end
      end

      if (busy) begin
        tap <= tap + 1'b1;
        if (tap == tap_bits'(fir_taps - 1)) begin
          busy <= 1'b0;
          last <= 1'b1;
        end
      end

      if (last) begin
        out_i      <= out_t'(acc_i >>> fir_shift); // gain 128 overall
        out_q      <= out_t'(acc_q >>> fir_shift);
        out_strobe <= 1'b1;
      end
    end
  end

  // accumulators, cleared at the start of each computation
  always_ff @(posedge clock) begin
    if (in_strobe && phase) begin
      acc_i <= '0;
      acc_q <= '0;
    end else if (busy) begin
      acc_i <= acc_i + prod_i;
      acc_q <= acc_q + prod_q;
    end
  end

endmodule

//--- src/receiver_decimator.sv
// RX decimation chain top, 18-bit I/Q mixer samples in, 24-bit I/Q out at 1/4800 rate
// CIC 48 -> CIC 50 -> FIR 2, each stage instantiated per channel
`timescale 1ns/1ps

module receiver_decimator (
  input  logic               clock,
  input  logic               rst_all,
  input  rx_decim_pkg::mix_t mixdata_i,
  input  rx_decim_pkg::mix_t mixdata_q,
  output logic               out_strobe, // one clock in 4800
  output rx_decim_pkg::out_t out_data_i,
  output rx_decim_pkg::out_t out_data_q
);

  import rx_decim_pkg::*;

  logic    strobe_s1;
  logic    strobe_s2;
  s1_out_t s1_data_i; // after decimate by 48
  s1_out_t s1_data_q;
  s2_out_t s2_data_i; // after decimate by 2400
  s2_out_t s2_data_q;

  decim_strobe_gen strobe_gen_i (
    .clock    (clock),
    .rst_all  (rst_all),
    .strobe_s1(strobe_s1),
    .strobe_s2(strobe_s2)
  );

  // first stage runs at full clock rate
  cic_decimator #(
    .stages(s1_stages), .rate(s1_rate), .in_bits(in_width), .out_bits(s1_out_width)
  ) s1_i (
    .clock(clock), .rst_all(rst_all), .in_strobe(1'b1), .out_strobe(strobe_s1),
    .in_data(mixdata_i), .out_data(s1_data_i)
  );

  cic_decimator #(
    .stages(s1_stages), .rate(s1_rate), .in_bits(in_width), .out_bits(s1_out_width)
  ) s1_q (
    .clock(clock), .rst_all(rst_all), .in_strobe(1'b1), .out_strobe(strobe_s1),
    .in_data(mixdata_q), .out_data(s1_data_q)
  );

  // second stage integrates at the stage 1 rate
  cic_decimator #(
    .stages(s2_stages), .rate(s2_rate), .in_bits(s1_out_width), .out_bits(s2_out_width)
  ) s2_i (
    .clock(clock), .rst_all(rst_all), .in_strobe(strobe_s1), .out_strobe(strobe_s2),
    .in_data(s1_data_i), .out_data(s2_data_i)
  );

  cic_decimator #(
    .stages(s2_stages), .rate(s2_rate), .in_bits(s1_out_width), .out_bits(s2_out_width)
  ) s2_q (
    .clock(clock), .rst_all(rst_all), .in_strobe(strobe_s1), .out_strobe(strobe_s2),
    .in_data(s1_data_q), .out_data(s2_data_q)
  );

  fir_decim2 fir_i (
    .clock     (clock),
    .rst_all   (rst_all),
    .in_strobe (strobe_s2),
    .in_i      (s2_data_i),
    .in_q      (s2_data_q),
    .out_strobe(out_strobe),
    .out_i     (out_data_i),
    .out_q     (out_data_q)
  );

endmodule

//--- sim/receiver_decimator_assertions.sv
// output strobe and data checks on the RX decimation chain
// bound into receiver_decimator, watches the output strobe protocol
`timescale 1ns/1ps

module receiver_decimator_assertions (
  input logic               clock,
  input logic               rst_all,
  input logic               out_strobe,
  input rx_decim_pkg::out_t out_data_i,
  input rx_decim_pkg::out_t out_data_q
);

  int fail_count = 0; // failed checks so far

  // strobe is a single-clock pulse
  a_single_pulse: assert property (
    @(posedge clock) disable iff (rst_all) out_strobe |=> !out_strobe
  ) else begin
    $error("out_strobe high on two consecutive clocks");
    fail_count++;
  end

  // no output sample while the chain is held in reset
  a_quiet_in_reset: assert property (
    @(posedge clock) rst_all |=> !out_strobe
  ) else begin
    $error("out_strobe pulsed during reset");
    fail_count++;
  end

  // outputs move only together with out_strobe
  a_hold_i: assert property (
    @(posedge clock) disable iff (rst_all) !out_strobe |-> $stable(out_data_i)
  ) else begin
    $error("out_data_i changed without out_strobe");
    fail_count++;
  end

  a_hold_q: assert property (
    @(posedge clock) disable iff (rst_all) !out_strobe |-> $stable(out_data_q)
  ) else begin
    $error("out_data_q changed without out_strobe");
    fail_count++;
  end

endmodule

bind receiver_decimator receiver_decimator_assertions assertions_i (.*);

//--- sim/tb_receiver_decimator.sv
// testbench for the RX decimation chain, DC table in, settled outputs checked
// against a shifted-product model of both CICs and the FIR gain
`timescale 1ns/1ps

module tb_receiver_decimator;

  import rx_decim_pkg::*;

  localparam int     n_entries         = 8;
  localparam int     strobes_per_entry = 12;
  localparam int     strobe_timeout    = 6000; // clocks per strobe wait
  localparam int     out_period        = 4800; // 48 * 50 * 2
  localparam int     reset_cycles      = 2;
  localparam longint cic1_gain         = 48 * 48 * 48 * 48;      // R^N of first CIC
  localparam longint cic2_gain         = 50 * 50 * 50 * 50 * 50; // R^N of second CIC

  logic   clock;
  logic   rst_all;
  mix_t   mixdata_i;
  mix_t   mixdata_q;
  logic   out_strobe;
  out_t   out_data_i;
  out_t   out_data_q;
  longint cycle_cnt = 0;
  longint last_strobe_cycle; // -1 until the first strobe after reset

  // columns: I input, Q input, check every output sample
  int stim_i   [n_entries] = '{0, 100, -100, 0, 131071, -131072, 5000, 77777};
  int stim_q   [n_entries] = '{0, 0, 0, -2500, -131072, 131071, -5000, 12345};
  bit stim_all [n_entries] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

  receiver_decimator dut_i (
    .clock     (clock),
    .rst_all   (rst_all),
    .mixdata_i (mixdata_i),
    .mixdata_q (mixdata_q),
    .out_strobe(out_strobe),
    .out_data_i(out_data_i),
    .out_data_q(out_data_q)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock; // 4 ns period
  end

  always @(posedge clock) cycle_cnt <= cycle_cnt + 1; // time base for strobe spacing

  // settled DC output, floor at each CIC truncation, then FIR gain 128
  function automatic out_t model_output(input mix_t x);
    longint s1;
    longint s2;
    s1 = (longint'(x) * cic1_gain) >>> 26;
    s2 = (s1 * cic2_gain) >>> 29;
    return out_t'(s2 * 128);
  endfunction

  task automatic halt_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic compare_sample(input string what, input out_t expected, input out_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s expected %0d got %0d", $time, what, expected, actual);
      halt_with_failure();
    end
  endtask

  task automatic compare_strobe(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s expected %b got %b", $time, what, expected, actual);
      halt_with_failure();
    end
  endtask

  task automatic compare_interval(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("[ERROR] %0t: %s expected %0d clocks got %0d", $time, what, expected, actual);
      halt_with_failure();
    end
  endtask

  // protocol checks of the bound checker module
  always @(dut_i.assertions_i.fail_count) begin
    if (dut_i.assertions_i.fail_count != 0) begin
      $display("a concurrent assertion on the DUT outputs failed");
      halt_with_failure();
    end
  end

  // called on a falling edge, leaves the chain out of reset
  task automatic apply_reset();
    rst_all = 1'b1;
    repeat (reset_cycles) begin
      @(negedge clock);
      compare_strobe("out_strobe in reset", 1'b0, out_strobe);
    end
    rst_all           = 1'b0;
    last_strobe_cycle = -1;
  endtask

  // returns on the falling edge inside the strobe cycle
  task automatic wait_out_strobe(input bit expect_zero);
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      if (waited > strobe_timeout) begin
        $display("timeout: out_strobe did not pulse within %0d clocks", strobe_timeout);
        halt_with_failure();
      end
      if (expect_zero && !out_strobe) begin // cleared outputs until the first new sample
        compare_sample("out_data_i before first strobe", out_t'(0), out_data_i);
        compare_sample("out_data_q before first strobe", out_t'(0), out_data_q);
      end
    end while (!out_strobe);
    if (last_strobe_cycle >= 0) begin
      compare_interval("out_strobe spacing", out_period, int'(cycle_cnt - last_strobe_cycle));
    end
    last_strobe_cycle = cycle_cnt;
  endtask

  // hold the current inputs for a run of strobes, check the settled tail
  task automatic hold_and_check(input int e, input bit zero_first);
    out_t exp_i;
    out_t exp_q;
    exp_i = model_output(mix_t'(stim_i[e]));
    exp_q = model_output(mix_t'(stim_q[e]));
    for (int n = 1; n <= strobes_per_entry; n++) begin
      wait_out_strobe(zero_first && n == 1);
      if (stim_all[e] || n > strobes_per_entry - 2) begin
        compare_sample("out_data_i", exp_i, out_data_i);
        compare_sample("out_data_q", exp_q, out_data_q); // exactly 0 when Q is 0
      end
    end
  endtask

  initial begin
    rst_all           = 1'b1;
    mixdata_i         = '0;
    mixdata_q         = '0;
    last_strobe_cycle = -1;
    apply_reset();

    for (int e = 0; e < n_entries; e++) begin
      mixdata_i = mix_t'(stim_i[e]); // on the falling edge
      mixdata_q = mix_t'(stim_q[e]);
      hold_and_check(e, e == 0);
    end

    // reset partway through an output period, last entry still applied
    wait_out_strobe(1'b0);
    repeat (1000) @(negedge clock);
    apply_reset();
    hold_and_check(n_entries - 1, 1'b1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- filelist.f
src/rx_decim_pkg.sv
src/cic_integrator.sv
src/cic_comb.sv
src/cic_decimator.sv
src/decim_strobe_gen.sv
src/fir_decim2.sv
src/receiver_decimator.sv
sim/receiver_decimator_assertions.sv
sim/tb_receiver_decimator.sv

//--- Bender.yml
package:
  name: receiver_decimator

sources:
  - target: any(rtl, simulation)
    files:
      - src/rx_decim_pkg.sv
      - src/cic_integrator.sv
      - src/cic_comb.sv
      - src/cic_decimator.sv
      - src/decim_strobe_gen.sv
      - src/fir_decim2.sv
      - src/receiver_decimator.sv

  - target: simulation
    files:
      - sim/receiver_decimator_assertions.sv
      - sim/tb_receiver_decimator.sv
